// ==== Makefile ====
# Verilator build and run for the peripheral subsystem

VERILATOR   ?= verilator
TOP         ?= tb_peripheral_subsystem
DUT_TOP     ?= peripheral_subsystem
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
TIMESCALE   ?= 1ns/1ps
VFLAGS      ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS  ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
PASS_STRING ?= SIMULATION PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

build: $(SIM)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STRING)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) $(filter src/%,$(SOURCES))

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
src/periph_pkg.sv
src/obi_to_reg.sv
src/reg_demux.sv
src/soc_ctrl.sv
src/uart_lite.sv
src/peripheral_subsystem.sv
testbench/peripheral_subsystem_sva.sv
testbench/tb_peripheral_subsystem.sv

// ==== src/obi_to_reg.sv ====
// ##############################
// OBI to register bus bridge
// ##############################

`default_nettype none

module obi_to_reg (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  periph_pkg::obi_req_t  obi_req_i,
  output periph_pkg::obi_resp_t obi_resp_o,
  output periph_pkg::reg_req_t  reg_req_o,
  input  periph_pkg::reg_rsp_t  reg_rsp_i
);

  logic        grant;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // Request goes straight onto the register bus
  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;
  assign reg_req_o.wstrb = obi_req_i.be;

  // Accepted when the target is ready
  assign grant = obi_req_i.req & reg_rsp_i.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= grant;
      err_q    <= grant & reg_rsp_i.error;
    end
  end

  // Write responses carry zero data
  always_ff @(posedge clk_i) begin
    if (grant) begin
      rdata_q <= obi_req_i.we ? 32'h0 : reg_rsp_i.rdata;
    end
  end

  assign obi_resp_o.gnt    = grant;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.err    = err_q;
  assign obi_resp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== src/periph_pkg.sv ====
// ##############################
// Bus structs, address map and
// register offsets
// ##############################

`default_nettype none

package periph_pkg;

  // OBI request and response
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // Register bus, valid/ready
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // ##############################
  // Address map
  // ##############################
  localparam int unsigned NUM_PERIPH     = 3;
  localparam int unsigned SOC_CTRL_IDX   = 0;
  localparam int unsigned UART_IDX       = 1;
  localparam int unsigned EXT_PERIPH_IDX = 2;

  localparam logic [31:0] SOC_CTRL_BASE   = 32'h2000_0000;
  localparam logic [31:0] UART_BASE       = 32'h2001_0000;
  localparam logic [31:0] EXT_PERIPH_BASE = 32'h2002_0000;
  // 64 KiB per region
  localparam logic [31:0] REGION_MASK     = 32'hFFFF_0000;

  // SoC control offsets
  localparam logic [31:0] SOC_EXIT_VALID_OFS = 32'h0;
  localparam logic [31:0] SOC_EXIT_VALUE_OFS = 32'h4;
  localparam logic [31:0] SOC_SCRATCH_OFS    = 32'h8;

  // UART offsets
  localparam logic [31:0] UART_CTRL_OFS   = 32'h0;
  localparam logic [31:0] UART_STATUS_OFS = 32'h4;
  localparam logic [31:0] UART_TXDATA_OFS = 32'h8;
  localparam logic [31:0] UART_RXDATA_OFS = 32'hC;

  localparam logic [15:0] UART_MIN_DIV = 16'd4;

endpackage

`default_nettype wire

// ==== src/peripheral_subsystem.sv ====
// ##############################
// Peripheral subsystem top level
// ##############################

`default_nettype none

module peripheral_subsystem (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  periph_pkg::obi_req_t  slave_req_i,
  output periph_pkg::obi_resp_t slave_resp_o,

  // SoC control
  output logic                  exit_valid_o,
  output logic [31:0]           exit_value_o,

  // UART
  input  logic                  uart_rx_i,
  output logic                  uart_tx_o,
  output logic                  uart_tx_en_o,
  output logic                  uart_intr_tx_empty_o,
  output logic                  uart_intr_rx_valid_o,

  // External peripheral port
  output periph_pkg::reg_req_t  ext_peripheral_slave_req_o,
  input  periph_pkg::reg_rsp_t  ext_peripheral_slave_resp_i
);

  import periph_pkg::*;

  reg_req_t                  periph_req;
  reg_rsp_t                  periph_rsp;
  reg_req_t [NUM_PERIPH-1:0] periph_slv_req;
  reg_rsp_t [NUM_PERIPH-1:0] periph_slv_rsp;

  assign ext_peripheral_slave_req_o     = periph_slv_req[EXT_PERIPH_IDX];
  assign periph_slv_rsp[EXT_PERIPH_IDX] = ext_peripheral_slave_resp_i;

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .arst_n_i,
    .obi_req_i  (slave_req_i),
    .obi_resp_o (slave_resp_o),
    .reg_req_o  (periph_req),
    .reg_rsp_i  (periph_rsp)
  );

  reg_demux reg_demux_i (
    .in_req_i  (periph_req),
    .in_rsp_o  (periph_rsp),
    .out_req_o (periph_slv_req),
    .out_rsp_i (periph_slv_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i    (periph_slv_req[SOC_CTRL_IDX]),
    .reg_rsp_o    (periph_slv_rsp[SOC_CTRL_IDX]),
    .exit_valid_o,
    .exit_value_o
  );

  uart_lite uart_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i       (periph_slv_req[UART_IDX]),
    .reg_rsp_o       (periph_slv_rsp[UART_IDX]),
    .uart_rx_i,
    .uart_tx_o,
    .uart_tx_en_o,
    .intr_tx_empty_o (uart_intr_tx_empty_o),
    .intr_rx_valid_o (uart_intr_rx_valid_o)
  );

endmodule

`default_nettype wire

// ==== src/reg_demux.sv ====
// ##############################
// Register bus decode and demux
// ##############################

`default_nettype none

module reg_demux (
  input  periph_pkg::reg_req_t                             in_req_i,
  output periph_pkg::reg_rsp_t                             in_rsp_o,
  output periph_pkg::reg_req_t [periph_pkg::NUM_PERIPH-1:0] out_req_o,
  input  periph_pkg::reg_rsp_t [periph_pkg::NUM_PERIPH-1:0] out_rsp_i
);

  import periph_pkg::*;

  logic [31:0]           region;
  logic [NUM_PERIPH-1:0] hit;

  // ##############################
  // Decode
  // ##############################
  assign region = in_req_i.addr & REGION_MASK;

  assign hit[SOC_CTRL_IDX]   = (region == SOC_CTRL_BASE);
  assign hit[UART_IDX]       = (region == UART_BASE);
  assign hit[EXT_PERIPH_IDX] = (region == EXT_PERIPH_BASE);

  // ##############################
  // Steering
  // ##############################
  always_comb begin
    // Unmapped addresses get an immediate error
    in_rsp_o.ready = 1'b1;
    in_rsp_o.error = 1'b1;
    in_rsp_o.rdata = 32'h0;
    for (int unsigned i = 0; i < NUM_PERIPH; i++) begin
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = in_req_i.valid & hit[i];
      if (hit[i]) begin
        in_rsp_o = out_rsp_i[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/soc_ctrl.sv ====
// ##############################
// SoC control: exit and scratch
// ##############################

`default_nettype none

module soc_ctrl (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 exit_valid_o,
  output logic [31:0]          exit_value_o
);

  import periph_pkg::*;

  logic [31:0] ofs;
  logic        sel_valid;
  logic        sel_value;
  logic        sel_scratch;
  logic        wr;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign ofs         = reg_req_i.addr & ~REGION_MASK;
  assign sel_valid   = (ofs == SOC_EXIT_VALID_OFS);
  assign sel_value   = (ofs == SOC_EXIT_VALUE_OFS);
  assign sel_scratch = (ofs == SOC_SCRATCH_OFS);
  assign wr          = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr) begin
      if (sel_valid && reg_req_i.wstrb[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (sel_value) begin
        exit_value_q <= merge_bytes(exit_value_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (sel_scratch) begin
        scratch_q <= merge_bytes(scratch_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
    end
  end

  // Always ready, undefined offsets read zero
  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = ~(sel_valid | sel_value | sel_scratch);
    reg_rsp_o.rdata = 32'h0;
    if (sel_valid) begin
      reg_rsp_o.rdata = {31'h0, exit_valid_q};
    end else if (sel_value) begin
      reg_rsp_o.rdata = exit_value_q;
    end else if (sel_scratch) begin
      reg_rsp_o.rdata = scratch_q;
    end
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// ==== src/uart_lite.sv ====
// ##############################
// 8N1 UART with register access
// ##############################

`default_nettype none

module uart_lite (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                 uart_rx_i,
  output logic                 uart_tx_o,
  output logic                 uart_tx_en_o,
  output logic                 intr_tx_empty_o,
  output logic                 intr_rx_valid_o
);

  import periph_pkg::*;

  logic [31:0] ofs;
  logic        sel_ctrl;
  logic        sel_status;
  logic        sel_txdata;
  logic        sel_rxdata;
  logic        wr;
  logic        rd_rxdata;
  logic        tx_en_q;
  logic        rx_en_q;
  logic [15:0] div_q;
  logic [15:0] div_eff;
  logic        tx_start;
  logic        tx_tick;
  logic        tx_busy_q;
  logic [9:0]  tx_shift_q;
  logic [15:0] tx_cnt_q;
  logic [3:0]  tx_bit_q;
  logic [2:0]  rx_sync_q;
  logic        rx_start;
  logic        rx_tick;
  logic        rx_done;
  logic        rx_busy_q;
  logic [15:0] rx_cnt_q;
  logic [3:0]  rx_bit_q;
  logic [7:0]  rx_shift_q;
  logic        rx_valid_q;
  logic        rx_ovf_q;
  logic [7:0]  rx_data_q;

  assign ofs        = reg_req_i.addr & ~REGION_MASK;
  assign sel_ctrl   = (ofs == UART_CTRL_OFS);
  assign sel_status = (ofs == UART_STATUS_OFS);
  assign sel_txdata = (ofs == UART_TXDATA_OFS);
  assign sel_rxdata = (ofs == UART_RXDATA_OFS);
  assign wr         = reg_req_i.valid & reg_req_i.write;
  assign rd_rxdata  = reg_req_i.valid & ~reg_req_i.write & sel_rxdata;

  // ##############################
  // Control register
  // ##############################
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_en_q <= 1'b0;
      rx_en_q <= 1'b0;
      div_q   <= UART_MIN_DIV;
    end else if (wr && sel_ctrl) begin
      if (reg_req_i.wstrb[0]) begin
        tx_en_q <= reg_req_i.wdata[0];
        rx_en_q <= reg_req_i.wdata[1];
      end
      if (reg_req_i.wstrb[2]) begin
        div_q[7:0] <= reg_req_i.wdata[23:16];
      end
      if (reg_req_i.wstrb[3]) begin
        div_q[15:8] <= reg_req_i.wdata[31:24];
      end
    end
  end

  assign div_eff = (div_q < UART_MIN_DIV) ? UART_MIN_DIV : div_q;

  // ##############################
  // Transmitter
  // ##############################
  assign tx_start = wr & sel_txdata & reg_req_i.wstrb[0] & tx_en_q & ~tx_busy_q;
  assign tx_tick  = tx_busy_q & (tx_cnt_q >= div_eff - 16'd1);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_busy_q <= 1'b0;
      tx_cnt_q  <= '0;
      tx_bit_q  <= '0;
    end else if (tx_start) begin
      tx_busy_q <= 1'b1;
      tx_cnt_q  <= '0;
      tx_bit_q  <= '0;
    end else if (tx_tick) begin
      tx_cnt_q <= '0;
      tx_bit_q <= tx_bit_q + 4'd1;
      // Stop bit done
      if (tx_bit_q == 4'd9) begin
        tx_busy_q <= 1'b0;
      end
    end else if (tx_busy_q) begin
      tx_cnt_q <= tx_cnt_q + 16'd1;
    end
  end

  // Frame is stop, data, start; shifted out LSB first
  always_ff @(posedge clk_i) begin
    if (tx_start) begin
      tx_shift_q <= {1'b1, reg_req_i.wdata[7:0], 1'b0};
    end else if (tx_tick) begin
      tx_shift_q <= {1'b1, tx_shift_q[9:1]};
    end
  end

  assign uart_tx_o = tx_busy_q ? tx_shift_q[0] : 1'b1;

  // ##############################
  // Receiver
  // ##############################
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_sync_q <= 3'b111;
    end else begin
      rx_sync_q <= {rx_sync_q[1:0], uart_rx_i};
    end
  end

  // Falling edge on the synchronized line
  assign rx_start = rx_en_q & ~rx_busy_q & rx_sync_q[2] & ~rx_sync_q[1];
  assign rx_tick  = rx_busy_q & (rx_cnt_q >= div_eff - 16'd1);
  assign rx_done  = rx_tick & (rx_bit_q == 4'd9) & rx_sync_q[1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_busy_q <= 1'b0;
      rx_cnt_q  <= '0;
      rx_bit_q  <= '0;
    end else if (rx_start) begin
      // Start half a period in, so ticks land mid-bit
      rx_busy_q <= 1'b1;
      rx_cnt_q  <= {1'b0, div_eff[15:1]};
      rx_bit_q  <= '0;
    end else if (rx_tick) begin
      rx_cnt_q <= '0;
      rx_bit_q <= rx_bit_q + 4'd1;
      // False start or end of frame
      if ((rx_bit_q == 4'd0 && rx_sync_q[1]) || rx_bit_q == 4'd9) begin
        rx_busy_q <= 1'b0;
      end
    end else if (rx_busy_q) begin
      rx_cnt_q <= rx_cnt_q + 16'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_tick && rx_bit_q != 4'd0 && rx_bit_q != 4'd9) begin
      rx_shift_q <= {rx_sync_q[1], rx_shift_q[7:1]};
    end
    if (rx_done) begin
      rx_data_q <= rx_shift_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_valid_q <= 1'b0;
      rx_ovf_q   <= 1'b0;
    end else begin
      if (rx_done) begin
        rx_valid_q <= 1'b1;
      end else if (rd_rxdata) begin
        rx_valid_q <= 1'b0;
      end
      // New byte over an unread one
      if (rx_done && rx_valid_q && !rd_rxdata) begin
        rx_ovf_q <= 1'b1;
      end else if (wr && sel_status) begin
        rx_ovf_q <= 1'b0;
      end
    end
  end

  // ##############################
  // Register read
  // ##############################
  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = ~(sel_ctrl | sel_status | sel_txdata | sel_rxdata);
    reg_rsp_o.rdata = 32'h0;
    if (sel_ctrl) begin
      reg_rsp_o.rdata = {div_q, 14'h0, rx_en_q, tx_en_q};
    end else if (sel_status) begin
      reg_rsp_o.rdata = {29'h0, rx_ovf_q, rx_valid_q, tx_busy_q};
    end else if (sel_rxdata) begin
      reg_rsp_o.rdata = {24'h0, rx_data_q};
    end
  end

  assign uart_tx_en_o    = tx_en_q;
  assign intr_tx_empty_o = tx_en_q & ~tx_busy_q;
  assign intr_rx_valid_o = rx_valid_q;

endmodule

`default_nettype wire

// ==== testbench/peripheral_subsystem_sva.sv ====
// ##############################
// Bound assertions on the OBI
// handshake and reset values
// ##############################

`default_nettype none

module peripheral_subsystem_sva (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input periph_pkg::obi_req_t  slave_req_i,
  input periph_pkg::obi_resp_t slave_resp_o,
  input logic                  uart_tx_o,
  input logic                  exit_valid_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures
  int unsigned fail_count = 0;

  // rvalid follows every gnt by exactly one cycle
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slave_resp_o.gnt |=> slave_resp_o.rvalid)
    else begin
      $error("rvalid missing one cycle after gnt");
      fail_count++;
    end

  no_rvalid_without_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !slave_resp_o.gnt |=> !slave_resp_o.rvalid)
    else begin
      $error("rvalid without a preceding gnt");
      fail_count++;
    end

  gnt_needs_req: assert property (@(posedge clk_i)
    slave_resp_o.gnt |-> slave_req_i.req)
    else begin
      $error("gnt high while req is low");
      fail_count++;
    end

  // Checked once reset has been low for a full cycle
  reset_outputs: assert property (@(posedge clk_i)
    (!arst_n_i && $past(!arst_n_i)) |-> (uart_tx_o && !exit_valid_o))
    else begin
      $error("UART line or exit valid wrong during reset");
      fail_count++;
    end

endmodule

bind peripheral_subsystem peripheral_subsystem_sva sva_i (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .slave_req_i  (slave_req_i),
  .slave_resp_o (slave_resp_o),
  .uart_tx_o    (uart_tx_o),
  .exit_valid_o (exit_valid_o)
);

`default_nettype wire

// ==== testbench/tb_peripheral_subsystem.sv ====
// ##############################
// Peripheral subsystem testbench with random OBI
// traffic, external responder, UART loopback and model
// ##############################

`default_nettype none

module tb_peripheral_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  import periph_pkg::*;

  localparam int unsigned CLK_PERIOD = 100;
  localparam int unsigned N_SOC      = 30;
  localparam int unsigned N_UNDEF    = 5;
  localparam int unsigned N_UNMAPPED = 20;
  localparam int unsigned N_EXT      = 40;
  localparam int unsigned N_BYTES    = 10;
  localparam int unsigned UART_DIV   = 8;
  localparam int unsigned POLL_LIMIT = 100;
  // Idle cycle, request cycle, up to four wait cycles, response cycle
  localparam int unsigned WORST_WAIT = 8;
  localparam int unsigned N_TXN      = 2 * N_SOC + N_UNDEF + 6 + N_UNMAPPED + 5 + N_EXT
                                       + (N_BYTES + 2) * 6;
  localparam int unsigned WATCHDOG_CYCLES = 10 + N_TXN * WORST_WAIT
                                            + (N_BYTES + 2) * 10 * UART_DIV + 2000;

  logic        clk;
  logic        arst_n;
  obi_req_t    slave_req;
  obi_resp_t   slave_resp;
  logic        exit_valid;
  logic [31:0] exit_value;
  wire         uart_line;
  logic        uart_tx_en;
  logic        intr_tx_empty;
  logic        intr_rx_valid;
  reg_req_t    ext_req;
  reg_rsp_t    ext_rsp;

  int unsigned errors;
  int unsigned ext_done;
  reg_req_t    ext_expected;
  logic [31:0] ext_mem [16];

  // Reference model
  logic [31:0] model_ext [16];
  logic        model_exit_valid;
  logic [31:0] model_exit_value;
  logic [31:0] model_scratch;

  // TX is looped back to RX
  peripheral_subsystem dut_i (
    .clk_i                       (clk),
    .arst_n_i                    (arst_n),
    .slave_req_i                 (slave_req),
    .slave_resp_o                (slave_resp),
    .exit_valid_o                (exit_valid),
    .exit_value_o                (exit_value),
    .uart_rx_i                   (uart_line),
    .uart_tx_o                   (uart_line),
    .uart_tx_en_o                (uart_tx_en),
    .uart_intr_tx_empty_o        (intr_tx_empty),
    .uart_intr_rx_valid_o        (intr_rx_valid),
    .ext_peripheral_slave_req_o  (ext_req),
    .ext_peripheral_slave_resp_i (ext_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] merge_strobes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // ##############################
  // OBI master
  // ##############################
  task automatic obi_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, output logic err,
                            output logic [31:0] rdata);
    @(negedge clk);
    slave_req.req   = 1'b1;
    slave_req.addr  = addr;
    slave_req.we    = we;
    slave_req.be    = be;
    slave_req.wdata = wdata;
    @(posedge clk);
    while (!slave_resp.gnt) begin
      @(posedge clk);
    end
    @(negedge clk);
    slave_req = '0;
    check_value("rvalid after gnt", 32'h1, 32'(slave_resp.rvalid));
    err   = slave_resp.err;
    rdata = slave_resp.rdata;
  endtask

  task automatic poll_uart_status(input logic [31:0] mask, input logic [31:0] value,
                                  input string what);
    int unsigned polls;
    logic        err;
    logic [31:0] rdata;
    polls = 0;
    do begin
      obi_access(UART_BASE + UART_STATUS_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
      polls++;
    end while (((rdata & mask) != value) && polls < POLL_LIMIT);
    assert ((rdata & mask) == value) else begin
      errors++;
      $display("UART status never showed %s after %0d polls", what, polls);
    end
  endtask

  // Write one byte once TX is idle and check the 8N1 frame at mid-bit
  task automatic send_and_sample_frame(input logic [7:0] tx_byte);
    logic        err;
    logic [31:0] rdata;
    logic [9:0]  frame;
    frame = {1'b1, tx_byte, 1'b0};
    poll_uart_status(32'h1, 32'h0, "tx idle");
    check_value("tx empty interrupt", 32'h1, 32'(intr_tx_empty));
    obi_access(UART_BASE + UART_TXDATA_OFS, 1'b1, 4'h1, {24'($urandom), tx_byte}, err, rdata);
    check_value("txdata write err", 32'h0, 32'(err));
    check_value("tx empty interrupt while busy", 32'h0, 32'(intr_tx_empty));
    repeat (UART_DIV / 2) @(negedge clk);
    for (int k = 0; k < 10; k++) begin
      check_value("uart frame bit", 32'(frame[4'(k)]), 32'(uart_line));
      if (k < 9) begin
        repeat (UART_DIV) @(negedge clk);
      end
    end
  endtask

  // ##############################
  // External responder
  // ##############################
  initial begin : ext_responder
    int unsigned wait_cycles;
    logic [3:0]  idx;
    ext_rsp = '0;
    forever begin
      @(posedge clk);
      if (arst_n && ext_req.valid) begin
        wait_cycles = $urandom_range(3, 0);
        repeat (wait_cycles) @(posedge clk);
        @(negedge clk);
        idx           = ext_req.addr[5:2];
        ext_rsp.ready = 1'b1;
        ext_rsp.rdata = ext_mem[idx];
        @(posedge clk);
        check_value("ext addr", ext_expected.addr, ext_req.addr);
        check_value("ext wdata", ext_expected.wdata, ext_req.wdata);
        check_value("ext write and strobes", 32'({ext_expected.write, ext_expected.wstrb}),
                    32'({ext_req.write, ext_req.wstrb}));
        if (ext_req.write) begin
          ext_mem[idx] = merge_strobes(ext_mem[idx], ext_req.wdata, ext_req.wstrb);
        end
        ext_done++;
        @(negedge clk);
        ext_rsp.ready = 1'b0;
        ext_rsp.rdata = 32'h0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  // ##############################
  // Stimulus and checks
  // ##############################
  initial begin : stimulus
    logic        err;
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [3:0]  idx;
    logic        we;
    logic        sel;
    logic [7:0]  tx_byte;
    int unsigned ext_before;
    void'($urandom(77));
    errors           = 0;
    ext_done         = 0;
    ext_expected     = '0;
    slave_req        = '0;
    model_exit_valid = 1'b0;
    model_exit_value = 32'h0;
    model_scratch    = 32'h0;
    for (int i = 0; i < 16; i++) begin
      ext_mem[4'(i)]   = (EXT_PERIPH_BASE + 32'(4 * i)) ^ 32'hC3A5_5A3C;
      model_ext[4'(i)] = ext_mem[4'(i)];
    end
    arst_n = 1'b0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;

    // Outputs straight after reset
    check_value("gnt after reset", 32'h0, 32'(slave_resp.gnt));
    check_value("rvalid after reset", 32'h0, 32'(slave_resp.rvalid));
    check_value("exit_valid_o after reset", 32'h0, 32'(exit_valid));
    check_value("exit_value_o after reset", 32'h0, exit_value);
    check_value("uart_tx_o after reset", 32'h1, 32'(uart_line));
    check_value("uart_tx_en_o after reset", 32'h0, 32'(uart_tx_en));
    check_value("tx empty interrupt after reset", 32'h0, 32'(intr_tx_empty));
    check_value("rx interrupt after reset", 32'h0, 32'(intr_rx_valid));
    check_value("ext valid after reset", 32'h0, 32'(ext_req.valid));

    // SoC control with byte strobes
    for (int i = 0; i < N_SOC; i++) begin
      sel   = ($urandom_range(1, 0) != 0);
      addr  = SOC_CTRL_BASE + (sel ? SOC_SCRATCH_OFS : SOC_EXIT_VALUE_OFS);
      wdata = $urandom;
      be    = 4'($urandom);
      obi_access(addr, 1'b1, be, wdata, err, rdata);
      check_value("soc write err", 32'h0, 32'(err));
      check_value("soc write rdata", 32'h0, rdata);
      if (sel) begin
        model_scratch = merge_strobes(model_scratch, wdata, be);
      end else begin
        model_exit_value = merge_strobes(model_exit_value, wdata, be);
      end
      obi_access(addr, 1'b0, 4'hF, 32'h0, err, rdata);
      check_value("soc readback err", 32'h0, 32'(err));
      check_value("soc readback", sel ? model_scratch : model_exit_value, rdata);
    end
    for (int i = 0; i < N_UNDEF; i++) begin
      addr = SOC_CTRL_BASE + {16'h0, 14'($urandom_range(16383, 3)), 2'b00};
      obi_access(addr, 1'b0, 4'hF, 32'h0, err, rdata);
      check_value("soc undefined err", 32'h1, 32'(err));
      check_value("soc undefined rdata", 32'h0, rdata);
    end

    // Exit outputs
    wdata = $urandom;
    obi_access(SOC_CTRL_BASE + SOC_EXIT_VALUE_OFS, 1'b1, 4'hF, wdata, err, rdata);
    model_exit_value = wdata;
    obi_access(SOC_CTRL_BASE + SOC_EXIT_VALID_OFS, 1'b1, 4'h1, $urandom | 32'h1, err, rdata);
    model_exit_valid = 1'b1;
    @(negedge clk);
    check_value("exit_valid_o set", 32'(model_exit_valid), 32'(exit_valid));
    check_value("exit_value_o", model_exit_value, exit_value);
    obi_access(SOC_CTRL_BASE + SOC_EXIT_VALID_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
    check_value("exit valid read", 32'h1, rdata);
    obi_access(SOC_CTRL_BASE + SOC_EXIT_VALID_OFS, 1'b1, 4'h1, $urandom & ~32'h1, err, rdata);
    model_exit_valid = 1'b0;
    @(negedge clk);
    check_value("exit_valid_o cleared", 32'(model_exit_valid), 32'(exit_valid));

    // Unmapped addresses
    obi_access(UART_BASE + UART_CTRL_OFS, 1'b1, 4'hF, {16'(UART_DIV), 16'h0}, err, rdata);
    ext_before = ext_done;
    for (int i = 0; i < N_UNMAPPED; i++) begin
      do begin
        addr = $urandom;
        if ($urandom_range(1, 0) == 0) begin
          addr[31:16] = 16'h2003 + 16'($urandom_range(15, 0));
        end
      end while ((addr & REGION_MASK) == SOC_CTRL_BASE ||
                 (addr & REGION_MASK) == UART_BASE ||
                 (addr & REGION_MASK) == EXT_PERIPH_BASE);
      we = 1'($urandom);
      obi_access(addr, we, 4'($urandom), $urandom, err, rdata);
      check_value("unmapped err", 32'h1, 32'(err));
      check_value("unmapped rdata", 32'h0, rdata);
    end
    check_value("unmapped ext accesses", 32'(ext_before), 32'(ext_done));
    obi_access(SOC_CTRL_BASE + SOC_SCRATCH_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
    check_value("scratch after unmapped", model_scratch, rdata);
    obi_access(SOC_CTRL_BASE + SOC_EXIT_VALUE_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
    check_value("exit value after unmapped", model_exit_value, rdata);
    obi_access(SOC_CTRL_BASE + SOC_EXIT_VALID_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
    check_value("exit valid after unmapped", 32'(model_exit_valid), rdata);
    obi_access(UART_BASE + UART_CTRL_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
    check_value("uart ctrl after unmapped", {16'(UART_DIV), 16'h0}, rdata);

    // External port with wait states
    ext_before = ext_done;
    for (int i = 0; i < N_EXT; i++) begin
      idx                = 4'($urandom);
      addr               = EXT_PERIPH_BASE + {26'h0, idx, 2'b00};
      we                 = 1'($urandom);
      be                 = 4'($urandom);
      wdata              = $urandom;
      ext_expected.valid = 1'b1;
      ext_expected.write = we;
      ext_expected.addr  = addr;
      ext_expected.wdata = wdata;
      ext_expected.wstrb = be;
      obi_access(addr, we, be, wdata, err, rdata);
      check_value("ext err", 32'h0, 32'(err));
      if (we) begin
        check_value("ext write rdata", 32'h0, rdata);
        model_ext[idx] = merge_strobes(model_ext[idx], wdata, be);
      end else begin
        check_value("ext read", model_ext[idx], rdata);
      end
    end
    check_value("ext accesses", 32'(ext_before + N_EXT), 32'(ext_done));

    // UART loopback
    obi_access(UART_BASE + UART_CTRL_OFS, 1'b1, 4'hF, {16'(UART_DIV), 14'h0, 1'b1, 1'b1},
               err, rdata);
    obi_access(UART_BASE + UART_CTRL_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
    check_value("uart ctrl", {16'(UART_DIV), 14'h0, 1'b1, 1'b1}, rdata);
    check_value("uart_tx_en_o", 32'h1, 32'(uart_tx_en));
    for (int n = 0; n < N_BYTES; n++) begin
      tx_byte = 8'($urandom);
      send_and_sample_frame(tx_byte);
      poll_uart_status(32'h2, 32'h2, "rx valid");
      check_value("rx interrupt before read", 32'h1, 32'(intr_rx_valid));
      obi_access(UART_BASE + UART_RXDATA_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
      check_value("uart rxdata", {24'h0, tx_byte}, rdata);
      check_value("rx interrupt after read", 32'h0, 32'(intr_rx_valid));
    end

    // Overflow keeps the newer byte
    send_and_sample_frame(8'($urandom));
    poll_uart_status(32'h2, 32'h2, "rx valid");
    tx_byte = 8'($urandom);
    send_and_sample_frame(tx_byte);
    poll_uart_status(32'h4, 32'h4, "rx overflow");
    obi_access(UART_BASE + UART_RXDATA_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
    check_value("rxdata after overflow", {24'h0, tx_byte}, rdata);
    obi_access(UART_BASE + UART_STATUS_OFS, 1'b1, 4'hF, $urandom, err, rdata);
    obi_access(UART_BASE + UART_STATUS_OFS, 1'b0, 4'hF, 32'h0, err, rdata);
    check_value("overflow cleared", 32'h0, rdata & 32'h4);

    @(negedge clk);
    $display("Errors: %0d, assertion failures: %0d", errors, dut_i.sva_i.fail_count);
    if (errors == 0 && dut_i.sva_i.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
